// ==== all.f ====
+incdir+verilog
verilog/sv39_pkg.sv
verilog/ptw_ctrl_pkg.sv
verilog/ptw_fsm.sv
verilog/ptw_level_ctr.sv
verilog/ptw_pte_check.sv
verilog/ptw_walk_ctx.sv
verilog/ptw_top.sv
dv/ptw_chk.sv
dv/ptw_tb.sv

// ==== Bender.yml ====
package:
  name: ptw

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/sv39_pkg.sv
      - verilog/ptw_ctrl_pkg.sv
      - verilog/ptw_fsm.sv
      - verilog/ptw_level_ctr.sv
      - verilog/ptw_pte_check.sv
      - verilog/ptw_walk_ctx.sv
      - verilog/ptw_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - dv/ptw_chk.sv
      - dv/ptw_tb.sv

// ==== dv/ptw_tb.sv ====
/*
 * Page table walker testbench
 * Table driven walks against a page table memory model with random delays
 */

`include "ptw_params.svh"

`default_nettype none

module ptw_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import sv39_pkg::*;
    import ptw_ctrl_pkg::*;

    localparam int         CLK_PERIOD = 8;
    localparam logic [1:0] NO_ERR     = 2'd3;

    // Table and page numbers
    localparam logic [`PTW_PPN_W-1:0] ROOT_PPN = 44'h000_0008_0123;
    localparam logic [`PTW_PPN_W-1:0] L2_PPN   = 44'h000_0009_0456;
    localparam logic [`PTW_PPN_W-1:0] L3_PPN   = 44'h000_000a_0789;
    localparam logic [`PTW_PPN_W-1:0] PG4K_PPN = 44'h000_0bee_f012;
    localparam logic [`PTW_PPN_W-1:0] PG2M_PPN = 44'h000_0012_3400;
    localparam logic [`PTW_PPN_W-1:0] PG1G_PPN = 44'h000_0340_0000;
    localparam logic [`PTW_VLEN-1:0]  IOVA_A   = 39'h12_3456_7abc;
    localparam logic [`PTW_VLEN-1:0]  IOVA_B   = 39'h4a_9876_5000;

    // Flag bytes, d a g u x w r v
    localparam logic [7:0] PTR      = 8'h01;
    localparam logic [7:0] PTR_G    = 8'h21;
    localparam logic [7:0] PTR_A    = 8'h41;
    localparam logic [7:0] LEAF_RW  = 8'h47;
    localparam logic [7:0] LEAF_RWD = 8'hc7;
    localparam logic [7:0] LEAF_RX  = 8'h4b;
    localparam logic [7:0] INVALID  = 8'h06;

    typedef enum logic [1:0] {
        OUT_UPDATE,
        OUT_ERROR,
        OUT_BARE
    } outcome_e;

    // One request, its page table and what must come back
    typedef struct packed {
        logic                    s1;
        logic [`PTW_PPN_W-1:0]   satp;
        logic [`PTW_VLEN-1:0]    iova;
        logic [`PTW_PSCID_W-1:0] pscid;
        logic                    store;
        pte_t [2:0]              pte;
        logic [1:0]              err_beat;
        outcome_e                outcome;
        cause_e                  cause;
        level_e                  lvl;
        logic                    glob;
    } row_t;

    row_t rows[$];
    bit   rows_ready = 1'b0;

    logic                    clk_i = 1'b0;
    logic                    rst_ni;
    logic                    miss_i;
    logic                    stage1_en_i;
    logic [`PTW_PPN_W-1:0]   satp_ppn_i;
    logic [`PTW_VLEN-1:0]    iova_i;
    logic [`PTW_PSCID_W-1:0] pscid_i;
    logic                    is_store_i;
    logic                    ar_valid_o;
    logic [`PTW_PLEN-1:0]    ar_addr_o;
    logic                    ar_ready_i;
    logic                    r_valid_i;
    pte_t                    r_data_i;
    logic                    r_err_i;
    logic                    r_ready_o;
    logic                    busy_o;
    logic                    update_o;
    logic [3*`PTW_VPN_W-1:0] up_vpn_o;
    logic [`PTW_PSCID_W-1:0] up_pscid_o;
    pte_t                    up_pte_o;
    logic                    up_is_2m_o;
    logic                    up_is_1g_o;
    logic                    error_o;
    cause_e                  cause_o;
    logic                    bare_o;

    ptw_top UUT (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .miss_i      (miss_i),
        .stage1_en_i (stage1_en_i),
        .satp_ppn_i  (satp_ppn_i),
        .iova_i      (iova_i),
        .pscid_i     (pscid_i),
        .is_store_i  (is_store_i),
        .ar_valid_o  (ar_valid_o),
        .ar_addr_o   (ar_addr_o),
        .ar_ready_i  (ar_ready_i),
        .r_valid_i   (r_valid_i),
        .r_data_i    (r_data_i),
        .r_err_i     (r_err_i),
        .r_ready_o   (r_ready_o),
        .busy_o      (busy_o),
        .update_o    (update_o),
        .up_vpn_o    (up_vpn_o),
        .up_pscid_o  (up_pscid_o),
        .up_pte_o    (up_pte_o),
        .up_is_2m_o  (up_is_2m_o),
        .up_is_1g_o  (up_is_1g_o),
        .error_o     (error_o),
        .cause_o     (cause_o),
        .bare_o      (bare_o)
    );

    bind ptw_top ptw_chk u_chk (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .ar_valid_i (ar_valid_o),
        .ar_addr_i  (ar_addr_o),
        .ar_ready_i (ar_ready_i),
        .r_valid_i  (r_valid_i),
        .r_ready_i  (r_ready_o),
        .update_i   (update_o),
        .error_i    (error_o),
        .busy_i     (busy_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "first error ends the run");
    endtask

    // A failed protocol assertion ends the run at once
    always @(UUT.u_chk.fail_cnt) begin
        if (UUT.u_chk.fail_cnt != 0)
            abort_run("Protocol assertion failed in the bound checker");
    end

    function automatic pte_t make_pte(input logic [`PTW_PPN_W-1:0] ppn,
                                      input logic [7:0] flags, input logic [9:0] rsv);
        pte_t p;
        p = {rsv, ppn, 2'b00, flags};
        return p;
    endfunction

    // Beat index at which a walk ends for a given level
    function automatic int beat_of(input level_e l);
        case (l)
            LVL1:    return 0;
            LVL2:    return 1;
            default: return 2;
        endcase
    endfunction

    // Sv39 table address for each read of the walk
    function automatic logic [`PTW_PLEN-1:0] expect_addr(input row_t rw, input int b);
        case (b)
            0:       return {rw.satp, rw.iova[38:30], 3'b000};
            1:       return {rw.pte[0].ppn, rw.iova[29:21], 3'b000};
            default: return {rw.pte[1].ppn, rw.iova[20:12], 3'b000};
        endcase
    endfunction

    task automatic check_addr(input logic [`PTW_PLEN-1:0] exp);
        if (ar_addr_o !== exp)
            abort_run($sformatf("Fail ar_addr_o: got 0x%h expected 0x%h", ar_addr_o, exp));
    endtask

    task automatic check_cause(input cause_e exp);
        if (cause_o !== exp)
            abort_run($sformatf("Fail cause_o: got 0x%h expected 0x%h", cause_o, exp));
    endtask

    task automatic check_update(input logic [3*`PTW_VPN_W-1:0] vpn,
                                input logic [`PTW_PSCID_W-1:0] pscid, input pte_t pte,
                                input logic is_2m, input logic is_1g);
        if (up_vpn_o !== vpn)
            abort_run($sformatf("Fail up_vpn_o: got 0x%h expected 0x%h", up_vpn_o, vpn));
        if (up_pscid_o !== pscid)
            abort_run($sformatf("Fail up_pscid_o: got 0x%h expected 0x%h", up_pscid_o, pscid));
        if (up_pte_o !== pte)
            abort_run($sformatf("Fail up_pte_o: got 0x%h expected 0x%h", up_pte_o, pte));
        if (up_is_2m_o !== is_2m)
            abort_run($sformatf("Fail up_is_2m_o: got 0x%h expected 0x%h", up_is_2m_o, is_2m));
        if (up_is_1g_o !== is_1g)
            abort_run($sformatf("Fail up_is_1g_o: got 0x%h expected 0x%h", up_is_1g_o, is_1g));
    endtask

    task automatic add_row(input logic s1, input logic [`PTW_VLEN-1:0] iova,
                           input logic [`PTW_PSCID_W-1:0] pscid, input logic store,
                           input pte_t p0, input pte_t p1, input pte_t p2,
                           input logic [1:0] err_beat, input outcome_e outcome,
                           input cause_e cause, input level_e lvl, input logic glob);
        row_t rw;
        rw = {s1, ROOT_PPN, iova, pscid, store, p2, p1, p0, err_beat, outcome, cause, lvl, glob};
        rows.push_back(rw);
    endtask

    task automatic build_table();
        pte_t z;
        z = '0;
        // Plain 4K walks, the second with G on the root pointer
        add_row(1, IOVA_A, 20'h00abc, 0, make_pte(L2_PPN, PTR, 0), make_pte(L3_PPN, PTR, 0),
                make_pte(PG4K_PPN, LEAF_RW, 0), NO_ERR, OUT_UPDATE, NO_CAUSE, LVL3, 0);
        add_row(1, IOVA_B, 20'hf00d1, 1, make_pte(L2_PPN, PTR_G, 0), make_pte(L3_PPN, PTR, 0),
                make_pte(PG4K_PPN, LEAF_RWD, 0), NO_ERR, OUT_UPDATE, NO_CAUSE, LVL3, 1);
        // Superpages
        add_row(1, IOVA_A, 20'h00001, 0, make_pte(PG1G_PPN, LEAF_RX, 0), z, z,
                NO_ERR, OUT_UPDATE, NO_CAUSE, LVL1, 0);
        add_row(1, IOVA_B, 20'h12345, 0, make_pte(L2_PPN, PTR_G, 0),
                make_pte(PG2M_PPN, LEAF_RW, 0), z, NO_ERR, OUT_UPDATE, NO_CAUSE, LVL2, 1);
        // Page faults
        add_row(1, IOVA_A, 20'h00002, 0, make_pte(L2_PPN, INVALID, 0), z, z,
                NO_ERR, OUT_ERROR, LOAD_PAGE_FAULT, LVL1, 0);
        add_row(1, IOVA_B, 20'h00003, 1, make_pte(L2_PPN, PTR, 0),
                make_pte(PG2M_PPN, LEAF_RWD, 10'h200), z,
                NO_ERR, OUT_ERROR, STORE_PAGE_FAULT, LVL2, 0);
        add_row(1, IOVA_A, 20'h00004, 0, make_pte(PG1G_PPN | 44'h1, LEAF_RX, 0), z, z,
                NO_ERR, OUT_ERROR, LOAD_PAGE_FAULT, LVL1, 0);
        add_row(1, IOVA_B, 20'h00005, 1, make_pte(L2_PPN, PTR, 0), make_pte(L3_PPN, PTR, 0),
                make_pte(PG4K_PPN, LEAF_RW, 0), NO_ERR, OUT_ERROR, STORE_PAGE_FAULT, LVL3, 0);
        add_row(1, IOVA_A, 20'h00006, 0, make_pte(L2_PPN, PTR, 0), make_pte(L3_PPN, PTR_A, 0),
                z, NO_ERR, OUT_ERROR, LOAD_PAGE_FAULT, LVL2, 0);
        add_row(1, IOVA_B, 20'h00007, 0, make_pte(L2_PPN, PTR, 0), make_pte(L3_PPN, PTR, 0),
                make_pte(PG4K_PPN, PTR, 0), NO_ERR, OUT_ERROR, LOAD_PAGE_FAULT, LVL3, 0);
        // Bus errors on each beat
        add_row(1, IOVA_A, 20'h00008, 0, make_pte(L2_PPN, PTR, 0), z, z,
                2'd0, OUT_ERROR, PT_DATA_CORRUPTION, LVL1, 0);
        add_row(1, IOVA_B, 20'h00009, 1, make_pte(L2_PPN, PTR, 0), make_pte(L3_PPN, PTR, 0), z,
                2'd1, OUT_ERROR, PT_DATA_CORRUPTION, LVL2, 0);
        add_row(1, IOVA_A, 20'h0000a, 0, make_pte(L2_PPN, PTR, 0), make_pte(L3_PPN, PTR, 0),
                make_pte(PG4K_PPN, LEAF_RW, 0), 2'd2, OUT_ERROR, PT_DATA_CORRUPTION, LVL3, 0);
        // Translation off
        add_row(0, IOVA_B, 20'h0000b, 0, z, z, z, NO_ERR, OUT_BARE, NO_CAUSE, LVL1, 0);
    endtask

    task automatic drive_miss(input row_t rw);
        miss_i      <= 1'b1;
        stage1_en_i <= rw.s1;
        satp_ppn_i  <= rw.satp;
        iova_i      <= rw.iova;
        pscid_i     <= rw.pscid;
        is_store_i  <= rw.store;
    endtask

    task automatic run_bare(input row_t rw);
        @(posedge clk_i);
        drive_miss(rw);
        @(negedge clk_i);
        if (!bare_o)
            abort_run("No bare_o in the cycle of a miss with stage 1 disabled");
        @(posedge clk_i);
        miss_i <= 1'b0;
        // A started walk would show one cycle after the miss
        @(negedge clk_i);
        if (ar_valid_o || busy_o)
            abort_run("Walk started for a miss with stage 1 disabled");
    endtask

    // Walk with a page table memory model answering the reads
    task automatic run_walk(input row_t rw);
        pte_t exp_pte;
        int   beat;
        int   delay;
        int   last;
        bit   in_data;
        bit   first;
        bit   finished;
        beat     = 0;
        delay    = $urandom % 4;
        last     = beat_of(rw.lvl);
        in_data  = 1'b0;
        first    = 1'b1;
        finished = 1'b0;
        @(posedge clk_i);
        drive_miss(rw);
        @(negedge clk_i);
        if (bare_o || busy_o)
            abort_run("Walker busy or bare in the cycle the miss was taken");
        while (!finished) begin
            @(posedge clk_i);
            if (first) begin
                // Second miss while busy, with other tags
                iova_i  <= ~rw.iova;
                pscid_i <= ~rw.pscid;
                first = 1'b0;
            end else begin
                miss_i <= 1'b0;
            end
            if (in_data) begin
                ar_ready_i <= 1'b0;
                if (delay == 0) begin
                    r_valid_i <= 1'b1;
                    r_data_i  <= rw.pte[beat];
                    r_err_i   <= (beat == rw.err_beat);
                end else begin
                    r_valid_i <= 1'b0;
                    delay--;
                end
            end else begin
                r_valid_i <= 1'b0;
                r_err_i   <= 1'b0;
                if (delay == 0) begin
                    ar_ready_i <= 1'b1;
                end else begin
                    ar_ready_i <= 1'b0;
                    delay--;
                end
            end
            @(negedge clk_i);
            if (!busy_o)
                abort_run("busy_o low before the walk reported its outcome");
            if (error_o) begin
                if (rw.outcome != OUT_ERROR || beat != last + 1)
                    abort_run("error_o not expected at this point of the walk");
                check_cause(rw.cause);
                finished = 1'b1;
            end else if (r_ready_o) begin
                if (update_o) begin
                    if (rw.outcome != OUT_UPDATE || beat != last)
                        abort_run("update_o not expected on this read");
                    exp_pte   = rw.pte[beat];
                    exp_pte.g = rw.glob;
                    check_update(rw.iova[38:12], rw.pscid, exp_pte,
                                 rw.lvl == LVL2, rw.lvl == LVL1);
                    finished = 1'b1;
                end else if (rw.outcome == OUT_UPDATE && beat == last) begin
                    abort_run("No update_o on the read that returned the leaf");
                end
                beat++;
                in_data = 1'b0;
                delay   = $urandom % 4;
            end else if (update_o) begin
                abort_run("update_o outside a read beat");
            end else if (beat > last) begin
                // Fault is reported in the cycle right after its read
                abort_run("No error_o in the cycle after the faulting read");
            end else if (ar_valid_o) begin
                check_addr(expect_addr(rw, beat));
                if (ar_ready_i) begin
                    in_data = 1'b1;
                    delay   = $urandom % 4;
                end
            end
        end
        @(posedge clk_i);
        miss_i     <= 1'b0;
        ar_ready_i <= 1'b0;
        r_valid_i  <= 1'b0;
        r_err_i    <= 1'b0;
    endtask

    // Exactly one outcome, then silence
    task automatic check_quiet();
        repeat (3) begin
            @(negedge clk_i);
            if (busy_o || ar_valid_o || update_o || error_o || bare_o)
                abort_run("Walker active after the outcome of the request");
        end
    endtask

    initial begin
        wait (rows_ready);
        #(rows.size() * 3 * 12 * CLK_PERIOD);
        $display("Timeout: walks still running when the watchdog expired");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'hc4c9));
        rst_ni      = 1'b0;
        miss_i      = 1'b0;
        stage1_en_i = 1'b0;
        satp_ppn_i  = '0;
        iova_i      = '0;
        pscid_i     = '0;
        is_store_i  = 1'b0;
        ar_ready_i  = 1'b0;
        r_valid_i   = 1'b0;
        r_data_i    = '0;
        r_err_i     = 1'b0;
        build_table();
        rows_ready = 1'b1;
        repeat (3) @(posedge clk_i);
        if (ar_valid_o || r_ready_o || update_o || error_o || bare_o || busy_o)
            abort_run("Outputs not low during reset");
        rst_ni <= 1'b1;
        foreach (rows[i]) begin
            if (rows[i].outcome == OUT_BARE) begin
                run_bare(rows[i]);
            end else begin
                run_walk(rows[i]);
            end
            check_quiet();
        end
        @(negedge clk_i);
        if (UUT.u_chk.fail_cnt == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "protocol assertion failed");
        end
    end

endmodule

`default_nettype wire

// ==== dv/ptw_chk.sv ====
/*
 * Read port and outcome protocol checker
 * Bound to the walker top level
 */

`include "ptw_params.svh"

`default_nettype none

module ptw_chk (
    input wire                  clk_i,
    input wire                  rst_ni,
    input wire                  ar_valid_i,
    input wire [`PTW_PLEN-1:0]  ar_addr_i,
    input wire                  ar_ready_i,
    input wire                  r_valid_i,
    input wire                  r_ready_i,
    input wire                  update_i,
    input wire                  error_i,
    input wire                  busy_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // Failed assertions so far, polled by the testbench
    int fail_cnt = 0;

    // Request held with the same address until accepted
    ar_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("ar_valid_o dropped or ar_addr_o changed before ar_ready_i");
        end

    // One outcome per walk
    outcome_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(update_i && error_i))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("update_o and error_o high in the same cycle");
        end

    r_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_ready_i |-> r_valid_i)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("r_ready_o high without r_valid_i");
        end

    // Walker is free right after reporting a fault
    error_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        error_i |=> !busy_i)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("busy_o still high after error_o");
        end

endmodule

`default_nettype wire

// ==== verilog/ptw_top.sv ====
/*
 * Sv39 IOMMU page table walker
 * Walks up to three levels on an IOTLB miss and returns a leaf or a fault
 */

`include "ptw_params.svh"

`default_nettype none

module ptw_top (
    input  wire                     clk_i,
    input  wire                     rst_ni,
    // Miss request from the IOTLB
    input  wire                     miss_i,
    input  wire                     stage1_en_i,
    input  wire  [`PTW_PPN_W-1:0]   satp_ppn_i,
    input  wire  [`PTW_VLEN-1:0]    iova_i,
    input  wire  [`PTW_PSCID_W-1:0] pscid_i,
    input  wire                     is_store_i,
    // PTE read port
    output logic                    ar_valid_o,
    output logic [`PTW_PLEN-1:0]    ar_addr_o,
    input  wire                     ar_ready_i,
    input  wire                     r_valid_i,
    input  sv39_pkg::pte_t          r_data_i,
    input  wire                     r_err_i,
    output logic                    r_ready_o,
    // Status and IOTLB update
    output logic                    busy_o,
    output logic                    update_o,
    output logic [3*`PTW_VPN_W-1:0] up_vpn_o,
    output logic [`PTW_PSCID_W-1:0] up_pscid_o,
    output sv39_pkg::pte_t          up_pte_o,
    output logic                    up_is_2m_o,
    output logic                    up_is_1g_o,
    output logic                    error_o,
    output ptw_ctrl_pkg::cause_e    cause_o,
    output logic                    bare_o
);
    import sv39_pkg::*;
    import ptw_ctrl_pkg::*;

    logic     start;
    logic     descend;
    logic     r_beat;
    level_e   lvl;
    verdict_e verdict;

    // A beat is the cycle the FSM accepts read data
    assign r_beat = r_ready_o;

    ptw_fsm u_fsm (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .miss_i      (miss_i),
        .stage1_en_i (stage1_en_i),
        .is_store_i  (is_store_i),
        .ar_ready_i  (ar_ready_i),
        .r_valid_i   (r_valid_i),
        .r_err_i     (r_err_i),
        .verdict_i   (verdict),
        .ar_valid_o  (ar_valid_o),
        .r_ready_o   (r_ready_o),
        .start_o     (start),
        .descend_o   (descend),
        .update_o    (update_o),
        .error_o     (error_o),
        .bare_o      (bare_o),
        .busy_o      (busy_o),
        .cause_o     (cause_o)
    );

    ptw_level_ctr u_level_ctr (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .start_i    (start),
        .descend_i  (descend),
        .lvl_o      (lvl),
        .up_is_2m_o (up_is_2m_o),
        .up_is_1g_o (up_is_1g_o)
    );

    ptw_pte_check u_pte_check (
        .pte_i      (r_data_i),
        .lvl_i      (lvl),
        .is_store_i (is_store_i),
        .verdict_o  (verdict)
    );

    ptw_walk_ctx u_walk_ctx (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .start_i    (start),
        .descend_i  (descend),
        .r_beat_i   (r_beat),
        .iova_i     (iova_i),
        .satp_ppn_i (satp_ppn_i),
        .pscid_i    (pscid_i),
        .pte_i      (r_data_i),
        .lvl_i      (lvl),
        .ar_addr_o  (ar_addr_o),
        .up_vpn_o   (up_vpn_o),
        .up_pscid_o (up_pscid_o),
        .up_pte_o   (up_pte_o)
    );

endmodule

`default_nettype wire

// ==== verilog/ptw_walk_ctx.sv ====
/*
 * Walk context
 * Holds IOVA, PSCID, table pointer and global flag, forms IOTLB update data
 */

`include "ptw_params.svh"

`default_nettype none

module ptw_walk_ctx (
    input  wire                     clk_i,
    input  wire                     rst_ni,
    input  wire                     start_i,
    input  wire                     descend_i,
    input  wire                     r_beat_i,
    input  wire  [`PTW_VLEN-1:0]    iova_i,
    input  wire  [`PTW_PPN_W-1:0]   satp_ppn_i,
    input  wire  [`PTW_PSCID_W-1:0] pscid_i,
    input  sv39_pkg::pte_t          pte_i,
    input  sv39_pkg::level_e        lvl_i,
    output logic [`PTW_PLEN-1:0]    ar_addr_o,
    output logic [3*`PTW_VPN_W-1:0] up_vpn_o,
    output logic [`PTW_PSCID_W-1:0] up_pscid_o,
    output sv39_pkg::pte_t          up_pte_o
);
    import sv39_pkg::*;

    logic [`PTW_VLEN-1:0]    iova_q;
    logic [`PTW_PSCID_W-1:0] pscid_q;
    logic [`PTW_PLEN-1:0]    pptr_q;
    logic [`PTW_VPN_W-1:0]   vpn_next;
    logic                    global_q;

    // Slice for the table below the current level
    assign vpn_next = (lvl_i == LVL1) ? iova_q[29:21] : iova_q[20:12];

    // Table pointer and request tags
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            iova_q  <= iova_i;
            pscid_q <= pscid_i;
            // Root table indexed by VPN[2]
            pptr_q  <= {satp_ppn_i, iova_i[38:30], 3'b000};
        end else if (descend_i) begin
            pptr_q  <= {pte_i.ppn, vpn_next, 3'b000};
        end
    end

    // Sticky global bit over all levels of one walk
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            global_q <= 1'b0;
        end else if (start_i) begin
            global_q <= 1'b0;
        end else if (r_beat_i) begin
            global_q <= global_q | pte_i.g;
        end
    end

    assign ar_addr_o  = pptr_q;
    assign up_vpn_o   = iova_q[38:12];
    assign up_pscid_o = pscid_q;

    // Leaf goes out in its own beat, fold in G from above
    always_comb begin
        up_pte_o   = pte_i;
        up_pte_o.g = global_q | pte_i.g;
    end

endmodule

`default_nettype wire

// ==== verilog/ptw_pte_check.sv ====
/*
 * Sv39 PTE checker
 * Classifies a returned PTE as descend, leaf or fault
 */

`default_nettype none

module ptw_pte_check (
    input  sv39_pkg::pte_t         pte_i,
    input  sv39_pkg::level_e       lvl_i,
    input  wire                    is_store_i,
    output ptw_ctrl_pkg::verdict_e verdict_o
);
    import sv39_pkg::*;
    import ptw_ctrl_pkg::*;

    logic is_leaf;
    logic misaligned;

    // R or X marks a leaf, otherwise a pointer
    assign is_leaf = pte_i.r | pte_i.x;

    // Superpage PPN must be aligned to its size
    assign misaligned = ((lvl_i == LVL1) && (|pte_i.ppn[17:0])) ||
                        ((lvl_i == LVL2) && (|pte_i.ppn[8:0]));

    always_comb begin
        if (!pte_i.v || (!pte_i.r && pte_i.w)) begin
            // Invalid, or write-only encoding
            verdict_o = PTE_FAULT;
        end else if (|pte_i.reserved) begin
            // Bits 63:54, no Svnapot or Svpbmt here
            verdict_o = PTE_FAULT;
        end else if (is_leaf) begin
            // A must be set, D too on a store
            if (!pte_i.a || !pte_i.r || (is_store_i && !pte_i.d) || misaligned) begin
                verdict_o = PTE_FAULT;
            end else begin
                verdict_o = PTE_LEAF;
            end
        end else if (pte_i.a || pte_i.d || pte_i.u) begin
            // A, D, U reserved on pointers
            verdict_o = PTE_FAULT;
        end else if (lvl_i == LVL3) begin
            // Pointer past the last level
            verdict_o = PTE_FAULT;
        end else begin
            verdict_o = PTE_DESCEND;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ptw_level_ctr.sv ====
/*
 * Page level counter
 * Tracks the walk level and derives the superpage size flags
 */

`default_nettype none

module ptw_level_ctr (
    input  wire              clk_i,
    input  wire              rst_ni,
    input  wire              start_i,
    input  wire              descend_i,
    output sv39_pkg::level_e lvl_o,
    output logic             up_is_2m_o,
    output logic             up_is_1g_o
);
    import sv39_pkg::*;

    level_e lvl_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lvl_q <= LVL1;
        end else if (start_i) begin
            // Every walk begins at the root table
            lvl_q <= LVL1;
        end else if (descend_i) begin
            case (lvl_q)
                LVL1:    lvl_q <= LVL2;
                LVL2:    lvl_q <= LVL3;
                // Checker never descends from the last level
                default: lvl_q <= LVL3;
            endcase
        end
    end

    assign lvl_o = lvl_q;

    // Leaf found at an upper level means a superpage
    assign up_is_1g_o = (lvl_q == LVL1);
    assign up_is_2m_o = (lvl_q == LVL2);

endmodule

`default_nettype wire

// ==== verilog/ptw_fsm.sv ====
/*
 * Page table walk FSM
 * Sequences PTE reads and raises update, error and bare pulses
 */

`default_nettype none

module ptw_fsm (
    input  wire                    clk_i,
    input  wire                    rst_ni,
    input  wire                    miss_i,
    input  wire                    stage1_en_i,
    input  wire                    is_store_i,
    input  wire                    ar_ready_i,
    input  wire                    r_valid_i,
    input  wire                    r_err_i,
    input  ptw_ctrl_pkg::verdict_e verdict_i,
    output logic                   ar_valid_o,
    output logic                   r_ready_o,
    output logic                   start_o,
    output logic                   descend_o,
    output logic                   update_o,
    output logic                   error_o,
    output logic                   bare_o,
    output logic                   busy_o,
    output ptw_ctrl_pkg::cause_e   cause_o
);
    import ptw_ctrl_pkg::*;

    state_e state_q, state_n;
    cause_e cause_q, cause_n;
    logic   store_q;

    // Walk in progress whenever we left IDLE
    assign busy_o = (state_q != IDLE);

    always_comb begin
        state_n    = state_q;
        cause_n    = cause_q;
        ar_valid_o = 1'b0;
        r_ready_o  = 1'b0;
        start_o    = 1'b0;
        descend_o  = 1'b0;
        update_o   = 1'b0;
        error_o    = 1'b0;
        bare_o     = 1'b0;
        cause_o    = NO_CAUSE;

        case (state_q)
            IDLE: begin
                // Misses only count here, a busy walker drops them
                if (miss_i) begin
                    if (stage1_en_i) begin
                        start_o = 1'b1;
                        cause_n = NO_CAUSE;
                        state_n = WAIT_GRANT;
                    end else begin
                        // No translation needed, answer right away
                        bare_o = 1'b1;
                    end
                end
            end

            WAIT_GRANT: begin
                // Address held by the context until accepted
                ar_valid_o = 1'b1;
                if (ar_ready_i) begin
                    state_n = PTE_LOOKUP;
                end
            end

            PTE_LOOKUP: begin
                if (r_valid_i) begin
                    r_ready_o = 1'b1;
                    if (r_err_i) begin
                        // Bus error wins over whatever the PTE says
                        cause_n = PT_DATA_CORRUPTION;
                        state_n = PROPAGATE_ERROR;
                    end else begin
                        case (verdict_i)
                            PTE_DESCEND: begin
                                descend_o = 1'b1;
                                state_n   = WAIT_GRANT;
                            end
                            PTE_LEAF: begin
                                update_o = 1'b1;
                                state_n  = IDLE;
                            end
                            default: begin
                                cause_n = store_q ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
                                state_n = PROPAGATE_ERROR;
                            end
                        endcase
                    end
                end
            end

            PROPAGATE_ERROR: begin
                error_o = 1'b1;
                cause_o = cause_q;
                state_n = IDLE;
            end

            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            cause_q <= NO_CAUSE;
            store_q <= 1'b0;
        end else begin
            state_q <= state_n;
            cause_q <= cause_n;
            // Access type captured with the miss
            if (start_o) begin
                store_q <= is_store_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ptw_ctrl_pkg.sv ====
/*
 * Walker control encodings
 * FSM states, PTE check verdicts and fault cause codes
 */

`include "ptw_params.svh"

`default_nettype none

package ptw_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        PROPAGATE_ERROR
    } state_e;

    // Outcome of one PTE check, consumed by the FSM
    typedef enum logic [1:0] {
        PTE_DESCEND,
        PTE_LEAF,
        PTE_FAULT
    } verdict_e;

    // IOMMU fault causes reported by the walker
    typedef enum logic [`PTW_CAUSE_W-1:0] {
        NO_CAUSE           = 12'd0,
        LOAD_PAGE_FAULT    = 12'd13,
        STORE_PAGE_FAULT   = 12'd15,
        PT_DATA_CORRUPTION = 12'd274
    } cause_e;

endpackage

`default_nettype wire

// ==== verilog/sv39_pkg.sv ====
/*
 * Sv39 page table format
 * PTE layout and page table level encoding
 */

`include "ptw_params.svh"

`default_nettype none

package sv39_pkg;

    // Sv39 PTE, MSB first
    typedef struct packed {
        logic [9:0]            reserved;
        logic [`PTW_PPN_W-1:0] ppn;
        logic [1:0]            rsw;
        logic                  d;
        logic                  a;
        logic                  g;
        logic                  u;
        logic                  x;
        logic                  w;
        logic                  r;
        logic                  v;
    } pte_t;

    // Walk level, LVL1 maps 1G and LVL2 maps 2M
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } level_e;

endpackage

`default_nettype wire

// ==== verilog/ptw_params.svh ====
/*
 * Sv39 page table walker widths
 * Address, page number, VPN slice, PSCID and cause code sizes
 */

`ifndef PTW_PARAMS_SVH
`define PTW_PARAMS_SVH

// Physical address width
`define PTW_PLEN 56

// IOVA width for Sv39
`define PTW_VLEN 39

// Physical page number width
`define PTW_PPN_W 44

// One VPN slice, three of them per IOVA
`define PTW_VPN_W 9

// Process soft-context ID
`define PTW_PSCID_W 20

// Fault cause code
`define PTW_CAUSE_W 12

`endif
